// File: hdl/dmem_consts.svh
`ifndef DMEM_CONSTS_SVH
`define DMEM_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Major opcodes, instr[6:2]
`define OP_LOAD            5'b00000
`define OP_STORE           5'b01000

// Exception causes
`define EXC_LOAD_MISALIGN  4'd4
`define EXC_STORE_MISALIGN 4'd6

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data RAM geometry and timing
`define DMEM_WORDS         1024
`define DMEM_WAIT          2        // Wait states before ack

// Load width encodings, stores share the low three
`define FUNCT_LB           3'b000
`define FUNCT_LH           3'b001
`define FUNCT_LW           3'b010
`define FUNCT_LBU          3'b100
`define FUNCT_LHU          3'b101

`endif

// File: hdl/dmem_pkg.sv
package dmem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline bundles
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [4:0]  opcode;
        logic [2:0]  funct;
        logic        nop;
        logic [4:0]  rd;
        logic [31:0] result;     // ALU result, or store data
        logic [31:0] addr;       // Effective address
        logic [3:0]  exc;
        logic        exc_valid;
        logic        halt;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [4:0]  opcode;
        logic [2:0]  funct;
        logic        nop;
        logic [4:0]  rd;
        logic [31:0] result;     // Loaded value for loads
        logic [3:0]  exc;
        logic        exc_valid;
        logic        halt;
    } mem_wb_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone classic
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

// File: hdl/byte_lane_unit.sv
`timescale 1ns/1ps
`include "dmem_consts.svh"

module byte_lane_unit (
    input  logic [1:0]  addr,
    input  logic [2:0]  funct,
    input  logic [31:0] store_data,
    input  logic        is_store,
    input  logic [31:0] load_word,
    output logic [3:0]  sel,
    output logic [31:0] store_lanes,
    output logic [31:0] load_value,
    output logic        misaligned
);

    localparam logic [1:0] SZ_BYTE = 2'd0;
    localparam logic [1:0] SZ_HALF = 2'd1;
    localparam logic [1:0] SZ_WORD = 2'd2;

    logic [1:0]  size;
    logic [3:0]  lane_mask;
    logic [31:0] load_shifted;

    always_comb begin
        case (funct)
            `FUNCT_LB, `FUNCT_LBU: size = SZ_BYTE;
            `FUNCT_LH, `FUNCT_LHU: size = SZ_HALF;
            default:               size = SZ_WORD;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Store side
    always_comb begin
        case (size)
            SZ_BYTE: lane_mask = 4'b0001 << addr;
            SZ_HALF: lane_mask = 4'b0011 << addr;
            default: lane_mask = 4'b1111;
        endcase
    end

    assign sel         = is_store ? lane_mask : 4'b1111;   // Reads fetch the whole word
    assign store_lanes = store_data << {addr, 3'b000};

    assign misaligned = (size == SZ_HALF && addr[0]) ||
                        (size == SZ_WORD && addr != 2'b00);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load side
    assign load_shifted = load_word >> {addr, 3'b000};     // Addressed byte to lane 0

    always_comb begin
        case (funct)
            `FUNCT_LB:  load_value = {{24{load_shifted[7]}}, load_shifted[7:0]};
            `FUNCT_LH:  load_value = {{16{load_shifted[15]}}, load_shifted[15:0]};
            `FUNCT_LW:  load_value = load_word;
            `FUNCT_LBU: load_value = {24'h0, load_shifted[7:0]};
            `FUNCT_LHU: load_value = {16'h0, load_shifted[15:0]};
            default:    load_value = load_word;
        endcase
    end

endmodule

// File: hdl/memory.sv
`timescale 1ns/1ps
`include "dmem_consts.svh"

module memory
    import dmem_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    flush,
    input  logic    stall_in,
    input  ex_mem_t ex_mem,
    output mem_wb_t mem_wb,
    output logic    stall_out,
    output wb_req_t wb_req,
    input  wb_rsp_t wb_rsp
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUS  = 2'd1;
    localparam logic [1:0] ST_HOLD = 2'd2;

    logic [1:0]  state;
    logic        drop;            // Flushed while the bus cycle runs
    logic [31:0] hold_word;       // Read word parked under back-pressure
    logic        is_load;
    logic        is_store;
    logic        mem_op;
    logic        misaligned;
    logic [3:0]  lane_sel;
    logic [31:0] store_lanes;
    logic [31:0] load_word;
    logic [31:0] load_value;
    mem_wb_t     out_next;

    assign is_load  = !ex_mem.nop && ex_mem.opcode == `OP_LOAD;
    assign is_store = !ex_mem.nop && ex_mem.opcode == `OP_STORE;
    assign mem_op   = ex_mem.valid && !ex_mem.exc_valid && !misaligned && (is_load || is_store);

    assign load_word = (state == ST_HOLD) ? hold_word : wb_rsp.dat;

    byte_lane_unit lanes (
        .addr       (ex_mem.addr[1:0]),
        .funct      (ex_mem.funct),
        .store_data (ex_mem.result),
        .is_store   (is_store),
        .load_word  (load_word),
        .sel        (lane_sel),
        .store_lanes(store_lanes),
        .load_value (load_value),
        .misaligned (misaligned)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outgoing bundle for the item at the input
    always_comb begin
        out_next.valid     = ex_mem.valid;
        out_next.pc        = ex_mem.pc;
        out_next.instr     = ex_mem.instr;
        out_next.opcode    = ex_mem.opcode;
        out_next.funct     = ex_mem.funct;
        out_next.nop       = ex_mem.nop;
        out_next.rd        = ex_mem.rd;
        out_next.result    = (mem_op && is_load) ? load_value : ex_mem.result;
        out_next.exc       = ex_mem.exc;
        out_next.exc_valid = ex_mem.exc_valid;
        out_next.halt      = ex_mem.halt;
        if (!ex_mem.exc_valid && misaligned && (is_load || is_store)) begin
            out_next.exc       = is_load ? `EXC_LOAD_MISALIGN : `EXC_STORE_MISALIGN;
            out_next.exc_valid = 1'b1;
        end
    end

    always_comb begin
        case (state)
            ST_IDLE: stall_out = stall_in || mem_op;
            ST_BUS:  stall_out = stall_in || !wb_rsp.ack || drop;
            default: stall_out = stall_in;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage FSM and bus master
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_IDLE;
            drop         <= 1'b0;
            mem_wb.valid <= 1'b0;
            wb_req.cyc   <= 1'b0;
            wb_req.stb   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (flush) begin
                        mem_wb.valid <= 1'b0;
                    end else if (!stall_in) begin
                        if (mem_op) begin
                            wb_req.cyc   <= 1'b1;
                            wb_req.stb   <= 1'b1;
                            wb_req.we    <= is_store;
                            wb_req.sel   <= lane_sel;
                            wb_req.adr   <= ex_mem.addr;
                            wb_req.dat   <= store_lanes;
                            mem_wb.valid <= 1'b0;
                            state        <= ST_BUS;
                        end else begin
                            mem_wb <= out_next;     // Pass-through, bubble or exception
                        end
                    end
                end
                ST_BUS: begin
                    if (wb_rsp.ack) begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        drop       <= 1'b0;
                        if (flush || drop) begin
                            state <= ST_IDLE;       // Result discarded
                        end else if (stall_in) begin
                            hold_word <= wb_rsp.dat;
                            state     <= ST_HOLD;
                        end else begin
                            mem_wb <= out_next;
                            state  <= ST_IDLE;
                        end
                    end else if (flush) begin
                        drop <= 1'b1;
                    end
                end
                ST_HOLD: begin
                    if (flush) begin
                        state <= ST_IDLE;
                    end else if (!stall_in) begin
                        mem_wb <= out_next;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb |-> wb_req.cyc);

    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        wb_req.stb && !wb_rsp.ack |=> $stable(wb_req));

    a_flush_kills: assert property (@(posedge clk) disable iff (reset)
        flush |=> !mem_wb.valid);

endmodule

// File: hdl/wb_dmem.sv
`timescale 1ns/1ps
`include "dmem_consts.svh"

module wb_dmem
    import dmem_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    localparam int AW = $clog2(`DMEM_WORDS);
    localparam int CW = $clog2(`DMEM_WAIT + 1);
    localparam logic [CW-1:0] LAST_WAIT = CW'(`DMEM_WAIT - 1);

    logic [31:0]   ram [`DMEM_WORDS] = '{default: 32'h0};
    logic [CW-1:0] wait_cnt;
    logic          ack_q;
    logic [31:0]   rd_data;
    logic [AW-1:0] word_idx;
    logic          access;

    assign word_idx = wb_req.adr[AW+1:2];
    assign access   = wb_req.cyc && wb_req.stb && !ack_q && wait_cnt == LAST_WAIT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wait-state counter and ack
    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q    <= 1'b0;
            wait_cnt <= '0;
        end else if (ack_q) begin
            ack_q <= 1'b0;                       // Single-cycle ack
        end else if (wb_req.cyc && wb_req.stb) begin
            if (wait_cnt == LAST_WAIT) begin
                ack_q    <= 1'b1;
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // RAM array, read data lands with ack
    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_req.sel[b]) begin
                        ram[word_idx][8*b +: 8] <= wb_req.dat[8*b +: 8];
                    end
                end
            end
            rd_data <= ram[word_idx];
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_data;

    a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
        ack_q |=> !ack_q);

endmodule

// File: hdl/dmem_subsystem.sv
`timescale 1ns/1ps

module dmem_subsystem
    import dmem_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    flush,
    input  logic    stall_in,
    input  ex_mem_t ex_mem,
    output logic    stall_out,
    output mem_wb_t mem_wb
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage to RAM bus
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    memory mem_stage (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .stall_in (stall_in),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .stall_out(stall_out),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp)
    );

    wb_dmem dmem (
        .clk   (clk),
        .reset (reset),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD = 40            // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: verification/dmem_subsystem_tb.sv
`timescale 1ns/1ps
`include "dmem_consts.svh"

module dmem_subsystem_tb
    import dmem_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DLY    = 2;
    localparam int MEM_WAITS    = `DMEM_WAIT + 1;   // stall_out cycles before a bus op is taken
    localparam int N_PASS       = 20;
    localparam int N_WORDS      = 8;
    localparam int N_MISAL      = 4;
    localparam int N_MIX        = 60;
    localparam int N_FLUSH      = 3;
    localparam int N_ITEMS      = N_PASS + 16 * N_WORDS + 14 * N_MISAL + N_MIX + 3 * N_FLUSH;
    localparam int DRAIN_CYCLES = 20;

    logic        clk;
    logic        reset    = 1'b1;
    logic        flush    = 1'b0;
    logic        stall_in = 1'b0;
    logic        stall_out;
    ex_mem_t     ex_mem   = '0;
    mem_wb_t     mem_wb;

    mem_wb_t     exp_q[$];
    logic [7:0]  shadow [4096] = '{default: 8'h00};   // Byte image of the RAM
    logic [31:0] word_addr [N_WORDS];
    logic [31:0] item_rng    = 32'd52;
    logic [31:0] stall_rng   = 32'd52;
    logic [31:0] pc_next     = 32'h0000_1000;
    logic        stall_noise = 1'b0;
    int          accepted    = 0;
    int          seen        = 0;
    logic [4:0]  alu_ops [4] = '{5'b00100, 5'b01100, 5'b01101, 5'b11000};
    logic [2:0]  load_functs [5] = '{`FUNCT_LB, `FUNCT_LH, `FUNCT_LW, `FUNCT_LBU, `FUNCT_LHU};

    tb_clock_gen #(.PERIOD(40)) clk_gen (.clk(clk));

    dmem_subsystem dmem_subsystem_i (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .stall_in (stall_in),
        .ex_mem   (ex_mem),
        .stall_out(stall_out),
        .mem_wb   (mem_wb)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    function automatic logic [31:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    function automatic ex_mem_t make_item(input logic [4:0] opcode, input logic [2:0] funct,
                                          input logic [31:0] addr, input logic [31:0] data);
        ex_mem_t     it;
        logic [31:0] r;
        r            = lcg_next(item_rng);
        it.valid     = 1'b1;
        it.pc        = pc_next;
        it.instr     = {r[31:15], funct, r[11:7], opcode, 2'b11};
        it.opcode    = opcode;
        it.funct     = funct;
        it.nop       = 1'b0;
        it.rd        = r[11:7];
        it.result    = data;
        it.addr      = addr;
        it.exc       = 4'd0;
        it.exc_valid = 1'b0;
        it.halt      = 1'b0;
        pc_next      = pc_next + 32'd4;
        return it;
    endfunction

    // Expected mem_wb for one accepted item, stores update the shadow bytes
    function automatic mem_wb_t ref_model(input ex_mem_t in);
        mem_wb_t     res;
        logic [1:0]  size;
        int          base;
        logic [31:0] word;
        res = '{valid: 1'b1, pc: in.pc, instr: in.instr, opcode: in.opcode, funct: in.funct,
                nop: in.nop, rd: in.rd, result: in.result, exc: in.exc,
                exc_valid: in.exc_valid, halt: in.halt};
        size = in.funct[1:0];                            // 0 byte, 1 half, 2 word
        base = int'(in.addr[11:0]);
        if (in.nop || in.exc_valid || (in.opcode != `OP_LOAD && in.opcode != `OP_STORE)) begin
            return res;
        end
        if ((size == 2'd1 && in.addr[0]) || (size == 2'd2 && in.addr[1:0] != 2'b00)) begin
            res.exc       = (in.opcode == `OP_LOAD) ? `EXC_LOAD_MISALIGN : `EXC_STORE_MISALIGN;
            res.exc_valid = 1'b1;
            return res;
        end
        if (in.opcode == `OP_STORE) begin
            for (int i = 0; i < (1 << size); i++) begin
                shadow[base + i] = in.result[8*i +: 8];
            end
            return res;
        end
        word = 32'h0;
        for (int i = 0; i < (1 << size); i++) begin
            word[8*i +: 8] = shadow[base + i];
        end
        if (!in.funct[2] && size == 2'd0) word = {{24{word[7]}}, word[7:0]};
        if (!in.funct[2] && size == 2'd1) word = {{16{word[15]}}, word[15:0]};
        res.result = word;
        return res;
    endfunction

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, what, got, want);
            $display("Regression failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic next_edge();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Present one item, hold it until stall_out is low, then record its expected result
    task automatic issue(input ex_mem_t item, input int exp_waits);
        int waits;
        waits  = 0;
        ex_mem = item;
        @(negedge clk);
        while (stall_out) begin
            waits++;
            @(negedge clk);
        end
        exp_q.push_back(ref_model(item));
        accepted++;
        if (exp_waits >= 0) check_equal("accept latency", waits, exp_waits);
        next_edge();
        ex_mem.valid = 1'b0;
    endtask

    task automatic flushed_load(input logic [31:0] addr);
        ex_mem = make_item(`OP_LOAD, `FUNCT_LW, addr, 32'h0);
        next_edge();                                     // Bus cycle starts here
        ex_mem.valid = 1'b0;                             // Upstream drops the flushed load
        flush        = 1'b1;
        @(negedge clk);
        check_equal("stall_out under flush", stall_out, 1);
        next_edge();
        flush = 1'b0;
        @(negedge clk);
        while (stall_out) begin
            @(negedge clk);
        end
        next_edge();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Back-pressure noise, result checker, watchdog
    always @(posedge clk) begin
        #DRIVE_DLY;
        stall_in = stall_noise ? (lcg_next(stall_rng) % 3 == 0) : 1'b0;
    end

    always @(negedge clk) begin
        mem_wb_t expected;
        if (!reset && mem_wb.valid && !stall_in && !flush) begin   // Taken at the next edge
            if (exp_q.size() == 0) begin
                $display("Result for pc %0h arrived with nothing pending", mem_wb.pc);
                $display("Regression failed");
                $fatal(1, "Unexpected result");
            end else begin
                expected = exp_q.pop_front();
                seen++;
                check_equal("pc", mem_wb.pc, expected.pc);
                check_equal("instr", mem_wb.instr, expected.instr);
                check_equal("opcode", mem_wb.opcode, expected.opcode);
                check_equal("funct", mem_wb.funct, expected.funct);
                check_equal("nop", mem_wb.nop, expected.nop);
                check_equal("rd", mem_wb.rd, expected.rd);
                check_equal("result", mem_wb.result, expected.result);
                check_equal("exc", mem_wb.exc, expected.exc);
                check_equal("exc_valid", mem_wb.exc_valid, expected.exc_valid);
                check_equal("halt", mem_wb.halt, expected.halt);
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES + 200 * N_ITEMS) @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not complete", 200 * N_ITEMS);
        $display("Regression failed");
        $fatal(1, "Watchdog expired");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    initial begin
        ex_mem_t     it;
        logic [31:0] r;
        logic [2:0]  fn;
        logic [1:0]  off;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        next_edge();

        for (int i = 0; i < N_PASS; i++) begin
            r       = lcg_next(item_rng);
            it      = make_item(alu_ops[r[1:0]], r[4:2], r, lcg_next(item_rng));
            it.halt = (i == N_PASS - 1);
            if (i % 5 == 4) begin
                it.opcode = `OP_LOAD;                    // Nop with a load opcode stays off the bus
                it.nop    = 1'b1;
            end
            issue(it, 0);
        end

        // Byte lanes and extension
        for (int w = 0; w < N_WORDS; w++) begin
            r            = lcg_next(item_rng);
            word_addr[w] = {20'h0, r[11:2], 2'b00};
            issue(make_item(`OP_STORE, `FUNCT_LW, word_addr[w], lcg_next(item_rng)), MEM_WAITS);
            r = lcg_next(item_rng);
            issue(make_item(`OP_STORE, `FUNCT_LB, word_addr[w] + r[1:0], r), MEM_WAITS);
            issue(make_item(`OP_STORE, `FUNCT_LH, word_addr[w] + {r[2], 1'b0},
                            lcg_next(item_rng)), MEM_WAITS);
        end
        for (int w = 0; w < N_WORDS; w++) begin
            for (int o = 0; o < 4; o++) begin
                issue(make_item(`OP_LOAD, `FUNCT_LB, word_addr[w] + o, 32'h0), MEM_WAITS);
                issue(make_item(`OP_LOAD, `FUNCT_LBU, word_addr[w] + o, 32'h0), MEM_WAITS);
                if (o % 2 == 0) begin
                    issue(make_item(`OP_LOAD, `FUNCT_LH, word_addr[w] + o, 32'h0), MEM_WAITS);
                    issue(make_item(`OP_LOAD, `FUNCT_LHU, word_addr[w] + o, 32'h0), MEM_WAITS);
                end
                if (o == 0) issue(make_item(`OP_LOAD, `FUNCT_LW, word_addr[w], 32'h0), MEM_WAITS);
            end
        end

        // Misaligned accesses and incoming exceptions leave memory alone
        for (int w = 0; w < N_MISAL; w++) begin
            for (int o = 1; o < 4; o++) begin
                issue(make_item(`OP_LOAD, `FUNCT_LW, word_addr[w] + o, 32'h0), 0);
                issue(make_item(`OP_STORE, `FUNCT_LW, word_addr[w] + o, lcg_next(item_rng)), 0);
                if (o % 2 == 1) begin
                    issue(make_item(`OP_LOAD, `FUNCT_LHU, word_addr[w] + o, 32'h0), 0);
                    issue(make_item(`OP_STORE, `FUNCT_LH, word_addr[w] + o, lcg_next(item_rng)), 0);
                end
            end
            issue(make_item(`OP_LOAD, `FUNCT_LW, word_addr[w], 32'h0), MEM_WAITS);
            it           = make_item(`OP_STORE, `FUNCT_LW, word_addr[w], lcg_next(item_rng));
            it.exc       = 4'd2;
            it.exc_valid = 1'b1;
            issue(it, 0);
            it           = make_item(`OP_LOAD, `FUNCT_LBU, word_addr[w] + 3, 32'h0);
            it.exc       = 4'd5;
            it.exc_valid = 1'b1;
            issue(it, 0);
            issue(make_item(`OP_LOAD, `FUNCT_LW, word_addr[w], 32'h0), MEM_WAITS);
        end

        // Random mix under stall_in pulses
        stall_noise = 1'b1;
        for (int i = 0; i < N_MIX; i++) begin
            r  = lcg_next(item_rng);
            fn = load_functs[r[10:8] % 5];
            off = r[15:14] & ~((2'd1 << fn[1:0]) - 2'd1);    // Aligned for the access size
            case (r[1:0])
                2'd0: it = make_item(5'b01100, r[6:4], r, lcg_next(item_rng));
                2'd1: it = make_item(`OP_STORE, {1'b0, fn[1:0]}, word_addr[r[4:2]] + off,
                                     lcg_next(item_rng));
                2'd2: it = make_item(`OP_LOAD, fn, word_addr[r[4:2]] + off, 32'h0);
                default: begin
                    off = (r[13:12] == 2'd0) ? 2'd1 : r[13:12];
                    it  = make_item(r[5] ? `OP_STORE : `OP_LOAD, `FUNCT_LW,
                                    word_addr[r[4:2]] + off, lcg_next(item_rng));
                end
            endcase
            issue(it, -1);
        end
        stall_noise = 1'b0;
        next_edge();

        // Flush in the middle of a load
        for (int k = 0; k < N_FLUSH; k++) begin
            issue(make_item(`OP_STORE, `FUNCT_LW, word_addr[k], lcg_next(item_rng)), MEM_WAITS);
            flushed_load(word_addr[k]);
            issue(make_item(`OP_LOAD, `FUNCT_LW, word_addr[k], 32'h0), MEM_WAITS);
        end

        // Bounded wait for the last results
        for (int c = 0; c < DRAIN_CYCLES && exp_q.size() != 0; c++) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Accepted %0d items but saw %0d results", accepted, seen);
            $display("Regression failed");
            $fatal(1, "Results missing at the end of the run");
        end
    end

endmodule

// File: dmem_subsystem.f
+incdir+hdl
hdl/dmem_pkg.sv
hdl/byte_lane_unit.sv
hdl/memory.sv
hdl/wb_dmem.sv
hdl/dmem_subsystem.sv
verification/tb_clock_gen.sv
verification/dmem_subsystem_tb.sv

// File: Makefile
# Verilator build and run of the data memory subsystem testbench
VERILATOR ?= verilator
TOP       ?= dmem_subsystem_tb
FILELIST  ?= dmem_subsystem.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
